// ==== hw/cpuIsaPkg.sv ====
// instruction set package: opcodes, ALU operation codes and the instruction word union
package cpuIsaPkg;

	// 5-bit opcode in the top bits of every instruction
	typedef enum logic [4:0] {
		opAdd  = 5'b00011,
		opSub  = 5'b00100,
		opAnd  = 5'b01010,
		opOr   = 5'b01011,
		opAddi = 5'b01100,
		opNeg  = 5'b10000,
		opNot  = 5'b10001,
		opOut  = 5'b10111,
		opHalt = 5'b11011
	} opcodeT;

	typedef enum logic [2:0] {
		aluPass = 3'd0, // result = b
		aluAdd  = 3'd1,
		aluSub  = 3'd2,
		aluAnd  = 3'd3,
		aluOr   = 3'd4,
		aluNeg  = 3'd5,
		aluNot  = 3'd6,
		aluInc  = 3'd7  // used by the fetch step for PC + 1
	} aluOpT;

	// three register operands
	typedef struct packed {
		opcodeT      opcode;
		logic [3:0]  ra;     // destination or source for out
		logic [3:0]  rb;
		logic [3:0]  rc;
		logic [14:0] unused;
	} regFormT;

	// two registers and a signed constant
	typedef struct packed {
		opcodeT      opcode;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [18:0] constVal; // sign-extended onto the bus
	} immFormT;

	typedef union packed {
		regFormT regForm;
		immFormT immForm;
	} instrWordT;

endpackage

// ==== hw/cpuCtrlPkg.sv ====
// datapath control package: bus source selects, register field selects and the control word
package cpuCtrlPkg;

	// exactly one source drives the bus in each step
	typedef enum logic [2:0] {
		srcNone   = 3'd0, // bus reads as zero
		srcPc     = 3'd1,
		srcZLow   = 3'd2,
		srcMdr    = 3'd3,
		srcReg    = 3'd4,
		srcConstC = 3'd5
	} busSrcT;

	// IR field that addresses the register file
	typedef enum logic [1:0] {
		selRa = 2'd0,
		selRb = 2'd1,
		selRc = 2'd2
	} regSelT;

	typedef struct packed {
		busSrcT           busSrc;
		regSelT           regSel;
		logic             marIn;
		logic             pcIn;
		logic             mdrIn;
		logic             irIn;
		logic             yIn;
		logic             zIn;
		logic             regIn;  // register file write from the bus
		logic             outIn;  // output port load
		logic             read;   // memory read, MDR takes memData
		cpuIsaPkg::aluOpT aluOp;
	} ctrlWordT;

endpackage

// ==== hw/registerFile.sv ====
// general register file: sixteen 32-bit registers, one read port, one write port, R0 reads zero
`timescale 1ns/1ps

module registerFile (
	input  logic        Clock,
	input  logic        reset,
	input  logic [3:0]  readAddr,
	output logic [31:0] readData,
	input  logic        writeEnable,
	input  logic [3:0]  writeAddr,
	input  logic [31:0] writeData
);

	logic [31:0] regs [16];

	// R0 is hardwired to zero on the read side
	assign readData = (readAddr == 4'd0) ? 32'd0 : regs[readAddr];

	always_ff @(posedge Clock) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= 32'd0;
		end else if (writeEnable && writeAddr != 4'd0) begin
			regs[writeAddr] <= writeData; // writes to R0 dropped
		end
	end

endmodule

// ==== hw/aluUnit.sv ====
// combinational ALU: Y and bus operands, result into Z
`timescale 1ns/1ps

module aluUnit (
	input  cpuIsaPkg::aluOpT op,
	input  logic [31:0]      a,      // from Y
	input  logic [31:0]      b,      // from the bus
	output logic [31:0]      result
);

	// all arithmetic wraps at 32 bits
	always_comb begin
		case (op)
			cpuIsaPkg::aluAdd: begin
				result = a + b;
			end
			cpuIsaPkg::aluSub: begin
				result = a - b;
			end
			cpuIsaPkg::aluAnd: begin
				result = a & b;
			end
			cpuIsaPkg::aluOr: begin
				result = a | b;
			end
			cpuIsaPkg::aluNeg: begin
				result = ~b + 32'd1; // two's complement of b only
			end
			cpuIsaPkg::aluNot: begin
				result = ~b;
			end
			cpuIsaPkg::aluInc: begin
				result = b + 32'd1; // PC increment during fetch
			end
			default: begin
				result = b; // pass
			end
		endcase
	end

endmodule

// ==== hw/controlSequencer.sv ====
// control step sequencer: step counter, halted flag and opcode decoder for the control word
`timescale 1ns/1ps

module controlSequencer (
	input  logic                 Clock,
	input  logic                 reset,
	input  cpuIsaPkg::opcodeT    opcode,
	output cpuCtrlPkg::ctrlWordT ctrl,
	output logic                 halted
);

	localparam logic [2:0] t0 = 3'd0;
	localparam logic [2:0] t1 = 3'd1;
	localparam logic [2:0] t2 = 3'd2;
	localparam logic [2:0] t3 = 3'd3;
	localparam logic [2:0] t4 = 3'd4;
	localparam logic [2:0] t5 = 3'd5;

	logic [2:0] step;
	logic [2:0] stepNext;
	logic haltNow;

	// ALU operation applied in T4
	function automatic cpuIsaPkg::aluOpT aluOpFor(input cpuIsaPkg::opcodeT op);
		case (op)
			cpuIsaPkg::opAdd, cpuIsaPkg::opAddi: return cpuIsaPkg::aluAdd;
			cpuIsaPkg::opSub: return cpuIsaPkg::aluSub;
			cpuIsaPkg::opAnd: return cpuIsaPkg::aluAnd;
			cpuIsaPkg::opOr:  return cpuIsaPkg::aluOr;
			cpuIsaPkg::opNeg: return cpuIsaPkg::aluNeg;
			cpuIsaPkg::opNot: return cpuIsaPkg::aluNot;
			default: return cpuIsaPkg::aluPass;
		endcase
	endfunction

	always_comb begin
		ctrl = '0;
		stepNext = step + 3'd1;
		haltNow = 1'b0;
		if (!halted) begin
			case (step)
				t0: begin
					ctrl.busSrc = cpuCtrlPkg::srcPc;
					ctrl.marIn = 1'b1;
					ctrl.aluOp = cpuIsaPkg::aluInc; // Z = PC + 1
					ctrl.zIn = 1'b1;
				end
				t1: begin
					ctrl.busSrc = cpuCtrlPkg::srcZLow;
					ctrl.pcIn = 1'b1;
					ctrl.read = 1'b1;
					ctrl.mdrIn = 1'b1;
				end
				t2: begin
					ctrl.busSrc = cpuCtrlPkg::srcMdr;
					ctrl.irIn = 1'b1;
				end
				t3: begin
					case (opcode)
						cpuIsaPkg::opAdd, cpuIsaPkg::opSub, cpuIsaPkg::opAnd,
						cpuIsaPkg::opOr, cpuIsaPkg::opAddi: begin
							ctrl.busSrc = cpuCtrlPkg::srcReg;
							ctrl.regSel = cpuCtrlPkg::selRb;
							ctrl.yIn = 1'b1; // first operand into Y
						end
						cpuIsaPkg::opNeg, cpuIsaPkg::opNot: begin
							stepNext = t4; // idle step, unary ops skip Y
						end
						cpuIsaPkg::opOut: begin
							ctrl.busSrc = cpuCtrlPkg::srcReg;
							ctrl.regSel = cpuCtrlPkg::selRa;
							ctrl.outIn = 1'b1;
							stepNext = t0;
						end
						default: begin
							haltNow = 1'b1; // halt and unknown opcodes
							stepNext = t3;
						end
					endcase
				end
				t4: begin
					ctrl.busSrc = cpuCtrlPkg::srcReg;
					ctrl.regSel = cpuCtrlPkg::selRc;
					if (opcode == cpuIsaPkg::opAddi)
						ctrl.busSrc = cpuCtrlPkg::srcConstC;
					else if (opcode == cpuIsaPkg::opNeg || opcode == cpuIsaPkg::opNot)
						ctrl.regSel = cpuCtrlPkg::selRb;
					ctrl.aluOp = aluOpFor(opcode);
					ctrl.zIn = 1'b1;
				end
				t5: begin
					ctrl.busSrc = cpuCtrlPkg::srcZLow;
					ctrl.regSel = cpuCtrlPkg::selRa;
					ctrl.regIn = 1'b1; // write back into ra
					stepNext = t0;
				end
				default: stepNext = t0;
			endcase
		end else begin
			stepNext = step; // parked until reset
		end
	end

	always_ff @(posedge Clock) begin
		if (reset) begin
			step <= t0;
			halted <= 1'b0;
		end else begin
			step <= stepNext;
			if (haltNow)
				halted <= 1'b1;
		end
	end

endmodule

// ==== hw/busDatapath.sv ====
// single-bus datapath: bus mux, PC, MAR, MDR, IR, Y, Z, output port, register file and ALU
`timescale 1ns/1ps

module busDatapath #(
	parameter logic [31:0] resetVector = 32'd0
) (
	input  logic                 Clock,
	input  logic                 reset,
	input  cpuCtrlPkg::ctrlWordT ctrl,
	output cpuIsaPkg::opcodeT    opcode,
	input  logic [31:0]          memData,
	output logic [31:0]          memAddr,
	output logic                 memRead,
	output logic [31:0]          outData,
	output logic                 outStrobe
);

	logic [31:0] bus;
	logic [31:0] pc;
	logic [31:0] mar;
	logic [31:0] mdr;
	cpuIsaPkg::instrWordT ir;
	logic [31:0] y;
	logic [31:0] z;
	logic [31:0] outReg;
	logic [31:0] regData;
	logic [31:0] aluResult;
	logic [31:0] constC;
	logic [3:0] regAddr;

	assign opcode = ir.regForm.opcode;
	assign constC = {{13{ir.immForm.constVal[18]}}, ir.immForm.constVal};
	assign memAddr = mar;
	assign memRead = ctrl.read;
	assign outData = outReg;

	always_comb begin
		case (ctrl.regSel)
			cpuCtrlPkg::selRb: regAddr = ir.regForm.rb;
			cpuCtrlPkg::selRc: regAddr = ir.regForm.rc;
			default: regAddr = ir.regForm.ra;
		endcase
	end

	// one source at a time, idle bus reads zero
	always_comb begin
		case (ctrl.busSrc)
			cpuCtrlPkg::srcPc:     bus = pc;
			cpuCtrlPkg::srcZLow:   bus = z;
			cpuCtrlPkg::srcMdr:    bus = mdr;
			cpuCtrlPkg::srcReg:    bus = regData;
			cpuCtrlPkg::srcConstC: bus = constC;
			default:               bus = 32'd0;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (reset) begin
			pc <= resetVector;
			outStrobe <= 1'b0;
		end else begin
			if (ctrl.pcIn)
				pc <= bus;
			outStrobe <= ctrl.outIn; // one cycle after the port loads
		end
	end

	always_ff @(posedge Clock) begin
		if (ctrl.marIn)
			mar <= bus;
		if (ctrl.mdrIn && ctrl.read)
			mdr <= memData; // word returned by memory
		if (ctrl.irIn)
			ir <= bus;
		if (ctrl.yIn)
			y <= bus;
		if (ctrl.zIn)
			z <= aluResult;
		if (ctrl.outIn)
			outReg <= bus;
	end

	registerFile regs (
		.Clock       (Clock),
		.reset       (reset),
		.readAddr    (regAddr),
		.readData    (regData),
		.writeEnable (ctrl.regIn),
		.writeAddr   (regAddr),
		.writeData   (bus)
	);

	aluUnit alu (
		.op     (ctrl.aluOp),
		.a      (y),
		.b      (bus),
		.result (aluResult)
	);

endmodule

// ==== hw/cpuTop.sv ====
// CPU top level: control sequencer driving the single-bus datapath
`timescale 1ns/1ps

module cpuTop #(
	parameter logic [31:0] resetVector = 32'd0 // PC after reset
) (
	input  logic        Clock,
	input  logic        reset,
	input  logic [31:0] memData,
	output logic [31:0] memAddr,
	output logic        memRead,
	output logic [31:0] outData,
	output logic        outStrobe,
	output logic        halted
);

	cpuCtrlPkg::ctrlWordT ctrl;
	cpuIsaPkg::opcodeT opcode;

	controlSequencer sequencer (
		.Clock  (Clock),
		.reset  (reset),
		.opcode (opcode),
		.ctrl   (ctrl),
		.halted (halted)
	);

	busDatapath #(
		.resetVector (resetVector)
	) datapath (
		.Clock     (Clock),
		.reset     (reset),
		.ctrl      (ctrl),
		.opcode    (opcode),
		.memData   (memData),
		.memAddr   (memAddr),
		.memRead   (memRead),
		.outData   (outData),
		.outStrobe (outStrobe)
	);

endmodule

// ==== tb/cpuTop_checker.sv ====
// bound checker for cpuTop: reset quiet strobes, single-cycle out strobe, sticky halt, fetch order
`timescale 1ns/1ps

module cpuTop_checker #(
	parameter logic [31:0] resetVector = 32'd0
) (
	input logic        Clock,
	input logic        reset,
	input logic [31:0] memAddr,
	input logic        memRead,
	input logic        outStrobe,
	input logic        halted
);

	logic seenFetch;      // a fetch happened since reset
	logic [31:0] lastFetch;
	int unsigned failCount = 0; // failed properties so far

	always_ff @(posedge Clock) begin
		if (reset) begin
			seenFetch <= 1'b0;
			lastFetch <= 32'd0;
		end else if (memRead) begin
			seenFetch <= 1'b1;
			lastFetch <= memAddr; // address of the previous fetch
		end
	end

	quietReset: assert property (@(posedge Clock) reset |=> !memRead && !outStrobe)
		else begin
			$error("memory read or output strobe active during or right after reset");
			failCount++;
		end

	singleStrobe: assert property (@(posedge Clock) disable iff (reset)
		outStrobe |=> !outStrobe)
		else begin
			$error("output strobe held high for two cycles");
			failCount++;
		end

	haltSticks: assert property (@(posedge Clock) disable iff (reset)
		halted |=> halted)
		else begin
			$error("halted dropped without a reset");
			failCount++;
		end

	// nothing moves once the CPU has stopped
	haltQuiet: assert property (@(posedge Clock) disable iff (reset)
		halted |-> !memRead && !outStrobe)
		else begin
			$error("memory read or output strobe after halt");
			failCount++;
		end

	firstFetch: assert property (@(posedge Clock) disable iff (reset)
		memRead && !seenFetch |-> memAddr == resetVector)
		else begin
			$error("first fetch does not address the reset vector");
			failCount++;
		end

	nextFetch: assert property (@(posedge Clock) disable iff (reset)
		memRead && seenFetch |-> memAddr == lastFetch + 32'd1)
		else begin
			$error("fetch address did not advance by one word");
			failCount++;
		end

endmodule

// ==== tb/cpuTop_tb.sv ====
// testbench for cpuTop: clock, reset, program memory, reference model, output checks and timeout
`timescale 1ns/1ps

module cpuTop_tb;

	logic Clock;
	logic reset;
	logic [31:0] memData;
	logic [31:0] memAddr;
	logic memRead;
	logic [31:0] outData;
	logic outStrobe;
	logic halted;

	logic [31:0] mem [64];
	logic [31:0] model [16]; // software copy of the register file
	logic [31:0] expected [$];
	logic [31:0] want;
	integer seed;
	int pc;
	int aluCount;
	int outCount;
	int cycles;
	int limit;

	cpuTop #(.resetVector(32'd0)) cpuTop_i (.*);

	bind cpuTop cpuTop_checker #(.resetVector(resetVector)) checker_i (.*);

	assign memData = mem[memAddr[5:0]]; // memory answers in the same cycle

	initial begin
		Clock = 1'b0;
		forever #10 Clock = ~Clock;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	// store one instruction and execute it on the software model
	task automatic addInstr(input cpuIsaPkg::opcodeT op, input logic [3:0] ra,
		input logic [3:0] rb, input logic [3:0] rc, input logic [18:0] k);
		cpuIsaPkg::instrWordT w;
		logic [31:0] r;
		w = '0;
		w.regForm.opcode = op;
		w.regForm.ra = ra;
		w.regForm.rb = rb;
		w.regForm.rc = rc;
		if (op == cpuIsaPkg::opAddi)
			w.immForm.constVal = k; // overlays rc and the unused bits
		mem[pc] = w;
		pc++;
		case (op)
			cpuIsaPkg::opAdd:  r = model[rb] + model[rc];
			cpuIsaPkg::opSub:  r = model[rb] - model[rc];
			cpuIsaPkg::opAnd:  r = model[rb] & model[rc];
			cpuIsaPkg::opOr:   r = model[rb] | model[rc];
			cpuIsaPkg::opNeg:  r = 32'd0 - model[rb];
			cpuIsaPkg::opNot:  r = ~model[rb];
			cpuIsaPkg::opAddi: r = model[rb] + 32'($signed(k));
			default:           r = 32'd0;
		endcase
		if (op == cpuIsaPkg::opOut) begin
			expected.push_back(model[ra]);
			outCount++;
		end else if (op != cpuIsaPkg::opHalt) begin
			aluCount++;
			if (ra != 4'd0)
				model[ra] = r; // R0 keeps reading zero
		end
	endtask

	// compare each output port value with the model
	always @(posedge Clock) begin
		if (!reset && outStrobe) begin
			if (expected.size() == 0) begin
				abortRun("an output strobe arrived with no expected value left");
			end else begin
				want = expected.pop_front();
				assert (outData == want)
				else abortRun($sformatf("ERROR outData: got %h, expected %h", outData, want));
			end
		end
	end

	// bus protocol properties live in the bound checker
	initial begin
		wait (cpuTop_i.checker_i.failCount != 0);
		abortRun("a bus protocol property in the bound checker failed");
	end

	initial begin
		logic [18:0] k;
		reset = 1'b1;
		seed = 32'he63c;
		pc = 0;
		aluCount = 0;
		outCount = 0;
		for (int i = 0; i < 64; i++)
			mem[i] = {cpuIsaPkg::opHalt, 27'(i)}; // spare words stop the CPU
		for (int i = 0; i < 16; i++)
			model[i] = 32'd0;
		for (int r = 1; r <= 8; r++) begin
			k = 19'($random(seed));
			if (r % 2 == 1)
				k[18] = 1'b1; // odd registers get negative constants
			addInstr(cpuIsaPkg::opAddi, 4'(r), 4'd0, 4'd0, k);
			addInstr(cpuIsaPkg::opOut, 4'(r), 4'd0, 4'd0, 19'd0);
		end
		addInstr(cpuIsaPkg::opAdd, 4'd9, 4'd1, 4'd3, 19'd0); // two negatives, wraps
		addInstr(cpuIsaPkg::opOut, 4'd9, 4'd0, 4'd0, 19'd0);
		addInstr(cpuIsaPkg::opSub, 4'd10, 4'd2, 4'd4, 19'd0);
		addInstr(cpuIsaPkg::opOut, 4'd10, 4'd0, 4'd0, 19'd0);
		addInstr(cpuIsaPkg::opAnd, 4'd11, 4'd5, 4'd6, 19'd0);
		addInstr(cpuIsaPkg::opOut, 4'd11, 4'd0, 4'd0, 19'd0);
		addInstr(cpuIsaPkg::opOr, 4'd12, 4'd7, 4'd8, 19'd0);
		addInstr(cpuIsaPkg::opOut, 4'd12, 4'd0, 4'd0, 19'd0);
		addInstr(cpuIsaPkg::opNeg, 4'd13, 4'd8, 4'd0, 19'd0); // Y still holds R7
		addInstr(cpuIsaPkg::opOut, 4'd13, 4'd0, 4'd0, 19'd0);
		addInstr(cpuIsaPkg::opNot, 4'd14, 4'd3, 4'd0, 19'd0);
		addInstr(cpuIsaPkg::opOut, 4'd14, 4'd0, 4'd0, 19'd0);
		addInstr(cpuIsaPkg::opAdd, 4'd0, 4'd1, 4'd2, 19'd0); // write to R0 is lost
		addInstr(cpuIsaPkg::opOut, 4'd0, 4'd0, 4'd0, 19'd0);
		addInstr(cpuIsaPkg::opHalt, 4'd0, 4'd0, 4'd0, 19'd0);
		// six cycles per ALU op, four per out, halt fetch and reset, doubled
		limit = 2 * (6 * aluCount + 4 * outCount + 4 + 5);

		repeat (5) @(posedge Clock);
		#2 reset = 1'b0;
		cycles = 0;
		while (!halted && cycles < limit) begin
			@(posedge Clock);
			#2 cycles++;
		end
		repeat (3) @(posedge Clock); // let the checker watch the halted CPU
		#2;
		if (!halted)
			abortRun("timeout: the CPU never reached halt");
		else if (expected.size() != 0)
			abortRun("halted with expected output values never seen");
		else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

// ==== sources.f ====
hw/cpuIsaPkg.sv
hw/cpuCtrlPkg.sv
hw/registerFile.sv
hw/aluUnit.sv
hw/controlSequencer.sv
hw/busDatapath.sv
hw/cpuTop.sv
tb/cpuTop_checker.sv
tb/cpuTop_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_top

sources:
  - hw/cpuIsaPkg.sv
  - hw/cpuCtrlPkg.sv
  - hw/registerFile.sv
  - hw/aluUnit.sv
  - hw/controlSequencer.sv
  - hw/busDatapath.sv
  - hw/cpuTop.sv
  - target: test
    files:
      - tb/cpuTop_checker.sv
      - tb/cpuTop_tb.sv
